// File: hdl/xlat_pkg.sv
// ####################################################################
// Widths, management register map and enums for the fetch MMU.
// Register offsets are byte addresses and must be word aligned.
// ####################################################################
`default_nettype none

package xlat_pkg;

  localparam int VADDR_W     = 32;
  localparam int PADDR_W     = 30;
  localparam int PAGE_W      = 20;
  localparam int OFFSET_W    = 12;
  localparam int FRAME_W     = 20;
  localparam int MAP_FRAME_W = 18;  // Only the top frame bits reach the bus.
  localparam int TLB_ENTRIES = 32;
  localparam int TLB_IDX_W   = 5;
  localparam int AXI_ADDR_W  = 8;
  localparam int AXI_DATA_W  = 32;

  // ##################################################################
  // Management register map.
  localparam logic [AXI_ADDR_W-1:0] REG_PAGE   = 8'h00;
  localparam logic [AXI_ADDR_W-1:0] REG_FRAME  = 8'h04;
  localparam logic [AXI_ADDR_W-1:0] REG_INDEX  = 8'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_CMD    = 8'h0C;  // Write only.
  localparam logic [AXI_ADDR_W-1:0] REG_VICTIM = 8'h10;  // Read only.
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h14;  // Read only.

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    OP_WRITE_INDEX  = 2'd0,
    OP_WRITE_VICTIM = 2'd1,
    OP_READ_INDEX   = 2'd2,
    OP_NONE         = 2'd3
  } tlb_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TLB_READ,
    ST_WRITE_RESP,
    ST_READ_RESP
  } mgmt_state_e;

endpackage

`default_nettype wire

// File: hdl/tlb_port_if.sv
// ####################################################################
// Management port of the TLB. A read returns the entry one cycle
// after index is presented with w_enable low.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

interface tlb_port_if
  import xlat_pkg::*;
();

  logic [TLB_IDX_W-1:0] index;
  logic                 w_enable;
  logic [PAGE_W-1:0]    w_page;
  logic [FRAME_W-1:0]   w_frame;
  logic [PAGE_W-1:0]    r_page;
  logic [FRAME_W-1:0]   r_frame;
  logic                 r_valid;

  modport mgmt (
    output index, w_enable, w_page, w_frame,
    input  r_page, r_frame, r_valid
  );

  modport cam (
    input  index, w_enable, w_page, w_frame,
    output r_page, r_frame, r_valid
  );

endinterface

`default_nettype wire

// File: hdl/tlb_cam.sv
// ####################################################################
// Fully associative TLB with one registered lookup per cycle.
// Pages must be unique; a multiple hit returns the OR of the indices.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module tlb_cam
  import xlat_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [PAGE_W-1:0]  page_in,
  input  logic               lookup_en,
  output logic [FRAME_W-1:0] frame_out,
  output logic               hit,
  tlb_port_if.cam            tlb
);

  logic [PAGE_W-1:0]      page_mem  [TLB_ENTRIES];
  logic [FRAME_W-1:0]     frame_mem [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [TLB_ENTRIES-1:0] match;
  logic [TLB_IDX_W-1:0]   found;

  // ##################################################################
  // Lookup.
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = valid_q[i] && (page_mem[i] == page_in);
    end
  end

  // A miss leaves found at zero, so entry 0 is read.
  always_comb begin
    found = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (match[i]) begin
        found = found | TLB_IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else if (lookup_en) begin
      hit <= |match;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en) begin
      frame_out <= frame_mem[found];
    end
  end

  // ##################################################################
  // Management port.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tlb.w_enable) begin
      valid_q[tlb.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tlb.w_enable) begin
      page_mem[tlb.index]  <= tlb.w_page;
      frame_mem[tlb.index] <= tlb.w_frame;
    end else begin
      tlb.r_page  <= page_mem[tlb.index];
      tlb.r_frame <= frame_mem[tlb.index];
      tlb.r_valid <= valid_q[tlb.index];
    end
  end

endmodule

`default_nettype wire

// File: hdl/xlat_stage.sv
// ####################################################################
// Fetch translation stage with one cycle of latency.
// The miss flag is informative only; no fault is raised.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module xlat_stage
  import xlat_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               valid_in,
  input  logic [VADDR_W-1:0] vaddr_in,
  output logic               ready_out,
  input  logic               ready_in,
  output logic               valid_out,
  output logic [PADDR_W-1:0] paddr_out,
  output logic               miss_out,
  output logic [PAGE_W-1:0]  page_out,
  output logic               lookup_en,
  input  logic [FRAME_W-1:0] frame_in,
  input  logic               hit_in
);

  logic                   valid_q;
  logic [PAGE_W-1:0]      page_q;
  logic [OFFSET_W-1:0]    offset_q;
  logic                   direct;
  logic [MAP_FRAME_W-1:0] frame;

  assign ready_out = ready_in;
  assign lookup_en = ready_in;  // The TLB result holds with the stage.
  assign page_out  = vaddr_in[VADDR_W-1 -: PAGE_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ready_in) begin
      valid_q <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_in) begin
      page_q   <= vaddr_in[VADDR_W-1 -: PAGE_W];
      offset_q <= vaddr_in[OFFSET_W-1:0];
    end
  end

  // Pages with both top bits set bypass the TLB.
  assign direct = page_q[PAGE_W-1] & page_q[PAGE_W-2];

  assign frame = direct ? page_q[MAP_FRAME_W-1:0] : frame_in[FRAME_W-1 -: MAP_FRAME_W];

  assign valid_out = valid_q;
  assign paddr_out = {frame, offset_q};
  assign miss_out  = ~direct & ~hit_in;

endmodule

`default_nettype wire

// File: hdl/victim_counter.sv
// ####################################################################
// Round-robin victim pointer for TLB replacement.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module victim_counter
  import xlat_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 advance,
  output logic [TLB_IDX_W-1:0] victim_index
);

  logic [TLB_IDX_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (advance) begin
      if (count_q == TLB_IDX_W'(TLB_ENTRIES - 1)) begin
        count_q <= '0;  // Wrap back to the first entry.
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign victim_index = count_q;

endmodule

`default_nettype wire

// File: hdl/tlb_mgmt_fsm.sv
// ####################################################################
// AXI4-Lite slave for TLB maintenance. Writes win over reads, and a
// single transaction is open at a time. Byte strobes are not used.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module tlb_mgmt_fsm
  import xlat_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  input  logic [TLB_IDX_W-1:0]  victim_index,
  output logic                  victim_advance,
  tlb_port_if.mgmt              tlb
);

  mgmt_state_e           state;
  logic [PAGE_W-1:0]     page_q;
  logic [FRAME_W-1:0]    frame_q;
  logic [TLB_IDX_W-1:0]  index_q;
  logic                  status_q;
  logic                  w_enable_q;
  logic [TLB_IDX_W-1:0]  w_index_q;
  logic [1:0]            bresp_q;
  logic [1:0]            rresp_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic                  wr_hs;
  logic                  rd_hs;
  logic                  cmd_sel;
  logic                  wr_ok;
  logic                  rd_ok;
  logic [AXI_DATA_W-1:0] rd_mux;
  tlb_op_e               wr_op;

  // ##################################################################
  // Handshakes and decode.
  assign wr_hs   = (state == ST_IDLE) && awvalid && wvalid;
  assign rd_hs   = (state == ST_IDLE) && arvalid && !awvalid && !wvalid;
  assign awready = wr_hs;
  assign wready  = wr_hs;
  assign arready = rd_hs;

  assign wr_op   = tlb_op_e'(wdata[1:0]);
  assign cmd_sel = wr_hs && (awaddr == REG_CMD);
  assign wr_ok   = (awaddr == REG_PAGE) || (awaddr == REG_FRAME) ||
                   (awaddr == REG_INDEX) || (awaddr == REG_CMD);

  // The counter steps on the handshake edge, after its value is taken.
  assign victim_advance = cmd_sel && (wr_op == OP_WRITE_VICTIM);

  always_comb begin
    rd_ok  = 1'b1;
    rd_mux = '0;
    case (araddr)
      REG_PAGE:   rd_mux = AXI_DATA_W'(page_q);
      REG_FRAME:  rd_mux = AXI_DATA_W'(frame_q);
      REG_INDEX:  rd_mux = AXI_DATA_W'(index_q);
      REG_VICTIM: rd_mux = AXI_DATA_W'(victim_index);
      REG_STATUS: rd_mux = AXI_DATA_W'(status_q);
      default:    rd_ok  = 1'b0;  // Includes REG_CMD.
    endcase
  end

  // ##################################################################
  // State and holding registers.
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      page_q     <= '0;
      frame_q    <= '0;
      index_q    <= '0;
      status_q   <= 1'b0;
      w_enable_q <= 1'b0;
    end else begin
      w_enable_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (wr_hs) begin
            state <= ST_WRITE_RESP;
            case (awaddr)
              REG_PAGE:  page_q  <= wdata[PAGE_W-1:0];
              REG_FRAME: frame_q <= wdata[FRAME_W-1:0];
              REG_INDEX: index_q <= wdata[TLB_IDX_W-1:0];
              REG_CMD: begin
                case (wr_op)
                  OP_WRITE_INDEX:  w_enable_q <= 1'b1;
                  OP_WRITE_VICTIM: w_enable_q <= 1'b1;
                  OP_READ_INDEX:   state <= ST_TLB_READ;
                  OP_NONE:         ;
                endcase
              end
              default: ;
            endcase
          end else if (rd_hs) begin
            state <= ST_READ_RESP;
          end
        end
        ST_TLB_READ: begin
          page_q   <= tlb.r_page;  // Entry was read during the handshake cycle.
          frame_q  <= tlb.r_frame;
          status_q <= tlb.r_valid;
          state    <= ST_WRITE_RESP;
        end
        ST_WRITE_RESP: begin
          if (bready) begin
            state <= ST_IDLE;
          end
        end
        ST_READ_RESP: begin
          if (rready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_sel) begin
      w_index_q <= (wr_op == OP_WRITE_VICTIM) ? victim_index : index_q;
    end
    if (wr_hs) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      rdata_q <= rd_mux;
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ##################################################################
  // Outputs.
  assign bvalid = (state == ST_WRITE_RESP);
  assign bresp  = bresp_q;
  assign rvalid = (state == ST_READ_RESP);
  assign rdata  = rdata_q;
  assign rresp  = rresp_q;

  assign tlb.index    = w_enable_q ? w_index_q : index_q;
  assign tlb.w_enable = w_enable_q;
  assign tlb.w_page   = page_q;
  assign tlb.w_frame  = frame_q;

endmodule

`default_nettype wire

// File: hdl/mmu_top.sv
// ####################################################################
// Fetch MMU top level with a TLB loaded over AXI4-Lite.
// wstrb is ignored, so every write replaces the whole register.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module mmu_top
  import xlat_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_valid_in,
  output logic                  fetch_ready_out,
  input  logic [VADDR_W-1:0]    fetch_vaddr_in,
  output logic                  fetch_valid_out,
  input  logic                  fetch_ready_in,
  output logic [PADDR_W-1:0]    fetch_paddr_out,
  output logic                  fetch_miss_out,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp
);

  logic [PAGE_W-1:0]    lookup_page;
  logic                 lookup_en;
  logic [FRAME_W-1:0]   lookup_frame;
  logic                 lookup_hit;
  logic [TLB_IDX_W-1:0] victim_index;
  logic                 victim_advance;

  tlb_port_if u_tlb_port ();

  xlat_stage u_xlat_stage (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (fetch_valid_in),
    .vaddr_in  (fetch_vaddr_in),
    .ready_out (fetch_ready_out),
    .ready_in  (fetch_ready_in),
    .valid_out (fetch_valid_out),
    .paddr_out (fetch_paddr_out),
    .miss_out  (fetch_miss_out),
    .page_out  (lookup_page),
    .lookup_en (lookup_en),
    .frame_in  (lookup_frame),
    .hit_in    (lookup_hit)
  );

  tlb_cam u_tlb_cam (
    .clk       (clk),
    .rst       (rst),
    .page_in   (lookup_page),
    .lookup_en (lookup_en),
    .frame_out (lookup_frame),
    .hit       (lookup_hit),
    .tlb       (u_tlb_port.cam)
  );

  tlb_mgmt_fsm u_tlb_mgmt_fsm (
    .clk            (clk),
    .rst            (rst),
    .awvalid        (awvalid),
    .awready        (awready),
    .awaddr         (awaddr),
    .wvalid         (wvalid),
    .wready         (wready),
    .wdata          (wdata),
    .bvalid         (bvalid),
    .bready         (bready),
    .bresp          (bresp),
    .arvalid        (arvalid),
    .arready        (arready),
    .araddr         (araddr),
    .rvalid         (rvalid),
    .rready         (rready),
    .rdata          (rdata),
    .rresp          (rresp),
    .victim_index   (victim_index),
    .victim_advance (victim_advance),
    .tlb            (u_tlb_port.mgmt)
  );

  victim_counter u_victim_counter (
    .clk          (clk),
    .rst          (rst),
    .advance      (victim_advance),
    .victim_index (victim_index)
  );

endmodule

`default_nettype wire

// File: dv/tb_mmu.sv
// ######################################################################
// Testbench for the fetch MMU. Fetch traffic only runs while the TLB is
// idle, so each expected result uses settled TLB contents.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_mmu
  import xlat_pkg::*;
();

  localparam int WAIT_LIMIT = 64;

  logic        clk = 1'b0;
  logic        rst;
  logic        fetch_valid_in;
  logic        fetch_ready_out;
  logic [31:0] fetch_vaddr_in;
  logic        fetch_valid_out;
  logic        fetch_ready_in;
  logic [29:0] fetch_paddr_out;
  logic        fetch_miss_out;
  logic        awvalid;
  logic        awready;
  logic [7:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [7:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  integer      seed = 65398;
  int          errors;
  int          checks;
  int          tests;
  int          test_base;
  string       cur_test;
  logic [19:0] model_page  [32];
  logic [19:0] model_frame [32];
  logic        model_valid [32];
  logic [19:0] old_page    [2];   // Entries 0 and 1 before their second victim write.
  logic [30:0] exp_q [$];         // Holds {miss, paddr} per accepted fetch.

  mmu_top u_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // Expected translation, built from the address split and the TLB model.
  function automatic logic [30:0] expected_xlat(input logic [31:0] vaddr);
    logic [19:0] page;
    logic [11:0] offset;
    logic [30:0] result;
    int          i;
    page   = vaddr[31:12];
    offset = vaddr[11:0];
    result = {1'b1, 18'h0, offset};
    if (page[19:18] == 2'b11) begin
      result = {1'b0, page[17:0], offset};  // Direct region.
    end else begin
      for (i = 0; i < 32; i++) begin
        if (model_valid[i] && model_page[i] == page) begin
          result = {1'b0, model_frame[i][19:2], offset};
        end
      end
    end
    return result;
  endfunction

  // A non-direct page that no other valid entry holds.
  function automatic logic [19:0] fresh_page(input int skip_idx);
    logic [31:0] r;
    logic [19:0] page;
    logic        clash;
    int          i;
    do begin
      r    = rand_word();
      page = r[19:0];
      if (page[19:18] == 2'b11) begin
        page[19] = 1'b0;
      end
      clash = 1'b0;
      for (i = 0; i < 32; i++) begin
        if (i != skip_idx && model_valid[i] && model_page[i] == page) begin
          clash = 1'b1;
        end
      end
    end while (clash);
    return page;
  endfunction

  // Mode 0 mapped, 1 direct, 2 both, 3 old and new pages of entries 0 and 1.
  function automatic logic [31:0] pick_vaddr(input int mode);
    logic [31:0] r;
    logic [31:0] s;
    logic [19:0] page;
    int          base;
    int          i;
    logic        found;
    r     = rand_word();
    s     = rand_word();
    page  = r[31:12];
    found = 1'b0;
    base  = int'(s[7:3]);
    if (mode == 1 || (mode == 2 && s[0])) begin
      page[19:18] = 2'b11;
    end else if (mode == 3) begin
      case (s[2:1])
        2'd0:    page = model_page[0];
        2'd1:    page = model_page[1];
        2'd2:    page = old_page[0];
        default: page = old_page[1];
      endcase
    end else begin
      if (page[19:18] == 2'b11) begin
        page[19] = 1'b0;
      end
      if (s[1]) begin
        for (i = 0; i < 32; i++) begin
          if (!found && model_valid[(base + i) % 32]) begin
            page  = model_page[(base + i) % 32];
            found = 1'b1;
          end
        end
      end
    end
    return {page, r[11:0]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_and_finish();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("Timeout in test %s while waiting for %s.", cur_test, what);
    report_and_finish();
  endtask

  task automatic end_test();
    tests++;
    $display("test %s finished with %0d errors", cur_test, errors - test_base);
    test_base = errors;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("the write address handshake");
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("the write response");
    end while (!bvalid);
    resp = bresp;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("the read address handshake");
    end while (!arready);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("the read data");
    end while (!rvalid);
    data = rdata;
    resp = rresp;
  endtask

  task automatic store_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_value("bresp", 32'(RESP_OKAY), 32'(resp));
  endtask

  task automatic expect_reg(input string what, input logic [7:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_value({what, " rresp"}, 32'(RESP_OKAY), 32'(resp));
    check_value(what, expected, data);
  endtask

  task automatic load_entry(input logic [4:0] idx, input logic [19:0] page,
                            input logic [19:0] frame);
    store_reg(REG_PAGE, 32'(page));
    store_reg(REG_FRAME, 32'(frame));
    store_reg(REG_INDEX, 32'(idx));
    store_reg(REG_CMD, 32'(OP_WRITE_INDEX));
    model_page[idx]  = page;
    model_frame[idx] = frame;
    model_valid[idx] = 1'b1;
  endtask

  // Presents count fetches with random gaps, then waits for every result.
  task automatic run_fetch(input int count, input int mode, input logic back_pressure);
    int          sent;
    int          cycles;
    logic [31:0] r;
    sent   = 0;
    cycles = 0;
    while (sent < count) begin
      @(posedge clk);
      cycles++;
      if (fetch_valid_in && fetch_ready_in) sent++;
      if (cycles > count * 20) abort_run("fetch acceptance");
      r = rand_word();
      if (!fetch_valid_in || fetch_ready_in) begin
        fetch_valid_in <= (sent < count) && (r[1:0] != 2'b00);
        fetch_vaddr_in <= pick_vaddr(mode);
      end
      fetch_ready_in <= back_pressure ? (r[3:2] != 2'b00) : 1'b1;
    end
    fetch_ready_in <= 1'b1;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("translated fetch results");
    end
  endtask

  // ####################################################################
  // Comparing process for the fetch output.
  initial begin : compare_outputs
    logic [30:0] expected;
    logic        held;
    logic [29:0] held_paddr;
    logic        held_miss;
    held       = 1'b0;
    held_paddr = '0;
    held_miss  = 1'b0;
    forever begin
      @(posedge clk);
      if (rst) begin
        held = 1'b0;
      end else begin
        check_value("ready out", 32'(fetch_ready_in), 32'(fetch_ready_out));
        if (held) begin  // Stalled outputs must not move.
          check_value("held valid", 32'd1, 32'(fetch_valid_out));
          check_value("held paddr", 32'(held_paddr), 32'(fetch_paddr_out));
          check_value("held miss", 32'(held_miss), 32'(fetch_miss_out));
        end
        if (fetch_valid_out && fetch_ready_in) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("Fetch output in test %s with no input pending.", cur_test);
          end else begin
            expected = exp_q.pop_front();
            check_value("miss", 32'(expected[30]), 32'(fetch_miss_out));
            if (expected[30]) begin
              check_value("offset", 32'(expected[11:0]), 32'(fetch_paddr_out[11:0]));
            end else begin
              check_value("paddr", 32'(expected[29:0]), 32'(fetch_paddr_out));
            end
          end
        end
        if (fetch_valid_in && fetch_ready_out) begin
          exp_q.push_back(expected_xlat(fetch_vaddr_in));
        end
        held       = fetch_valid_out && !fetch_ready_in;
        held_paddr = fetch_paddr_out;
        held_miss  = fetch_miss_out;
      end
    end
  end

  // ####################################################################
  // Test sequence.
  initial begin
    logic [31:0] r;
    logic [1:0]  resp;
    logic [4:0]  idx;
    logic [19:0] page;
    int          k;
    rst            = 1'b1;
    fetch_valid_in = 1'b0;
    fetch_vaddr_in = '0;
    fetch_ready_in = 1'b1;
    awvalid        = 1'b0;
    awaddr         = '0;
    wvalid         = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    bready         = 1'b1;
    arvalid        = 1'b0;
    araddr         = '0;
    rready         = 1'b1;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    test_base      = 0;
    for (k = 0; k < 32; k++) begin
      model_page[k]  = '0;
      model_frame[k] = '0;
      model_valid[k] = 1'b0;
    end
    old_page[0] = '0;
    old_page[1] = '0;

    cur_test = "reset";
    for (k = 0; k < 8; k++) begin
      @(posedge clk);
      if (k > 0) begin
        check_value("outputs in reset", 32'd0, {29'h0, fetch_valid_out, bvalid, rvalid});
      end
    end
    rst <= 1'b0;
    @(posedge clk);
    check_value("outputs after reset", 32'd0, {29'h0, fetch_valid_out, bvalid, rvalid});
    expect_reg("victim after reset", REG_VICTIM, 32'd0);
    end_test();

    cur_test = "registers";
    r = rand_word();
    store_reg(REG_PAGE, r);
    expect_reg("page", REG_PAGE, {12'h0, r[19:0]});
    r = rand_word();
    store_reg(REG_FRAME, r);
    expect_reg("frame", REG_FRAME, {12'h0, r[19:0]});
    r = rand_word();
    store_reg(REG_INDEX, r);
    expect_reg("index", REG_INDEX, {27'h0, r[4:0]});
    axi_read(8'h18, r, resp);
    check_value("unmapped rresp", 32'(RESP_SLVERR), 32'(resp));
    axi_read(REG_CMD, r, resp);
    check_value("cmd rresp", 32'(RESP_SLVERR), 32'(resp));
    axi_write(REG_VICTIM, 32'd5, resp);
    check_value("victim bresp", 32'(RESP_SLVERR), 32'(resp));
    expect_reg("victim unchanged", REG_VICTIM, 32'd0);
    end_test();

    cur_test = "indexed";
    for (k = 0; k < 12; k++) begin
      r    = rand_word();
      idx  = r[4:0];
      page = fresh_page(int'(idx));
      load_entry(idx, page, r[31:12]);
    end
    for (k = 0; k < 32; k++) begin
      if (model_valid[k]) begin
        store_reg(REG_INDEX, k);
        store_reg(REG_CMD, 32'(OP_READ_INDEX));
        expect_reg("read page", REG_PAGE, 32'(model_page[k]));
        expect_reg("read frame", REG_FRAME, 32'(model_frame[k]));
        expect_reg("read status", REG_STATUS, 32'd1);
      end
    end
    idx = 5'd0;
    for (k = 31; k >= 0; k--) begin
      if (!model_valid[k]) idx = 5'(k);
    end
    store_reg(REG_INDEX, 32'(idx));
    store_reg(REG_CMD, 32'(OP_READ_INDEX));
    expect_reg("empty status", REG_STATUS, 32'd0);
    end_test();

    cur_test = "mapped";
    run_fetch(80, 0, 1'b0);
    end_test();

    cur_test = "direct";
    run_fetch(60, 1, 1'b1);
    run_fetch(80, 2, 1'b1);
    end_test();

    cur_test = "victim";
    for (k = 0; k < 34; k++) begin
      idx = 5'(k % 32);
      expect_reg("victim index", REG_VICTIM, 32'(idx));
      if (k >= 32) old_page[k - 32] = model_page[idx];
      page = fresh_page(int'(idx));
      r    = rand_word();
      store_reg(REG_PAGE, 32'(page));
      store_reg(REG_FRAME, {12'h0, r[19:0]});
      store_reg(REG_CMD, 32'(OP_WRITE_VICTIM));
      model_page[idx]  = page;
      model_frame[idx] = r[19:0];
      model_valid[idx] = 1'b1;
    end
    expect_reg("victim wrap", REG_VICTIM, 32'd2);
    run_fetch(40, 3, 1'b0);
    run_fetch(40, 0, 1'b1);
    end_test();

    report_and_finish();
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/xlat_pkg.sv
hdl/tlb_port_if.sv
hdl/tlb_cam.sv
hdl/xlat_stage.sv
hdl/victim_counter.sv
hdl/tlb_mgmt_fsm.sv
hdl/mmu_top.sv
dv/tb_mmu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fetch MMU testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_mmu -o tb_mmu_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mmu_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "sim passed" "$SIM_LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
